/* hdl/rp_pkg.sv */
package rp_pkg;

  //////////////////////////////////////////////////////////////////////
  // analog path widths
  //////////////////////////////////////////////////////////////////////

  localparam int ADC_W       = 14;  // raw converter word
  localparam int ADC_TRUNC_W = 12;  // captured sample after truncation
  localparam int DAC_W       = 14;  // DAC word, also generator/controller streams
  localparam int SUM_W       = 15;  // stream sum, one guard bit
  localparam int CH_N        = 2;   // two analog channels

  // DAC saturation limits, two's complement before code inversion
  localparam logic [DAC_W-1:0] DAC_POS_SAT = 14'h1fff;
  localparam logic [DAC_W-1:0] DAC_NEG_SAT = 14'h2000;

  //////////////////////////////////////////////////////////////////////
  // reset sequencing
  //////////////////////////////////////////////////////////////////////

  localparam int SYNC_STAGES = 2;   // lock / ready synchronizer depth
  localparam int RST_LEN     = 16;  // adc_clk cycles held after lock and ready

  localparam int RST_CNT_W = $clog2(RST_LEN + 1);
  localparam logic [RST_CNT_W-1:0] RST_CNT_END = RST_CNT_W'(RST_LEN);

  //////////////////////////////////////////////////////////////////////
  // daisy chain and expansion connector
  //////////////////////////////////////////////////////////////////////

  localparam int DAISY_W = 16;
  localparam logic [DAISY_W-1:0] DAISY_IDLE_PAT = 16'h1234;  // link test word

  localparam int EXP_W = 8;  // pins per connector side

  // daisy mode bits
  localparam int MODE_W        = 3;
  localparam int MODE_SYNC     = 0;  // trigger sync over the chain
  localparam int MODE_ALT_OUT  = 1;  // trigger out on expansion pin 0
  localparam int MODE_ASG_TRIG = 2;  // generator trigger instead of scope

endpackage

/* hdl/rp_reset_seq.sv */
module rp_reset_seq (
  input  logic adc_clk,
  input  logic rst_n_i,       // board reset, sync, active low
  input  logic pll_locked_i,  // from clock PLL, async
  input  logic idly_rdy_i,    // input delay controller ready, async
  output logic adc_rstn_o     // ADC domain reset, active low
);

  // synchronizer chains, newest sample in bit 0
  logic [rp_pkg::SYNC_STAGES-1:0] lock_sync;
  logic [rp_pkg::SYNC_STAGES-1:0] rdy_sync;
  logic                           lock_ok;
  logic                           rdy_ok;

  logic [rp_pkg::RST_CNT_W-1:0] rst_cnt;  // cycles with all conditions met

  //////////////////////////////////////////////////////////////////////
  // status synchronizers
  //////////////////////////////////////////////////////////////////////

  // ready comes from the delay controller's reference clock, so it
  // gets the same treatment as the lock
  always_ff @(posedge adc_clk) begin
    if (!rst_n_i) begin
      lock_sync <= '0;  // treat as unlocked
      rdy_sync  <= '0;
    end else begin
      lock_sync <= {lock_sync[rp_pkg::SYNC_STAGES-2:0], pll_locked_i};
      rdy_sync  <= {rdy_sync[rp_pkg::SYNC_STAGES-2:0], idly_rdy_i};
    end
  end

  assign lock_ok = lock_sync[rp_pkg::SYNC_STAGES-1];
  assign rdy_ok  = rdy_sync[rp_pkg::SYNC_STAGES-1];

  //////////////////////////////////////////////////////////////////////
  // release counter
  //////////////////////////////////////////////////////////////////////

  // any dropped condition restarts the count and pulls reset back low
  always_ff @(posedge adc_clk) begin
    if (!rst_n_i || !lock_ok || !rdy_ok) begin
      rst_cnt    <= '0;
      adc_rstn_o <= 1'b0;
    end else if (rst_cnt != rp_pkg::RST_CNT_END) begin
      rst_cnt    <= rst_cnt + 1'b1;
      // release on the edge where the count completes
      adc_rstn_o <= (rst_cnt == rp_pkg::RST_CNT_END - 1'b1);
    end
    // count done: hold released
  end

endmodule

/* hdl/rp_adc_capture.sv */
module rp_adc_capture (
  input  logic adc_clk,
  input  logic adc_rstn_i,
  input  logic digital_loop_i,  // replace ADC data with DAC sums
  input  logic [rp_pkg::CH_N-1:0][rp_pkg::ADC_W-1:0]       adc_raw_i,  // parallel lanes
  input  logic [rp_pkg::CH_N-1:0][rp_pkg::SUM_W-1:0]       dac_sum_i,  // unsaturated sums
  output logic [rp_pkg::CH_N-1:0][rp_pkg::ADC_TRUNC_W-1:0] adc_dat_o
);

  // truncation keeps the top bits of a 14 bit word
  localparam int TRUNC_LSB = rp_pkg::ADC_W - rp_pkg::ADC_TRUNC_W;

  logic [rp_pkg::CH_N-1:0][rp_pkg::ADC_W-1:0] adc_cnv;  // two's complement, stage 1

  //////////////////////////////////////////////////////////////////////
  // stage 1: code conversion
  //////////////////////////////////////////////////////////////////////

  // converter gives unsigned code with negative slope
  // flipping all but the msb lands on two's complement
  always_ff @(posedge adc_clk) begin
    for (int ch = 0; ch < rp_pkg::CH_N; ch++) begin
      adc_cnv[ch] <= {adc_raw_i[ch][rp_pkg::ADC_W-1],
                      ~adc_raw_i[ch][rp_pkg::ADC_W-2:0]};
    end
  end

  //////////////////////////////////////////////////////////////////////
  // stage 2: channel crossing / loopback
  //////////////////////////////////////////////////////////////////////

  // board lanes are swapped, out 0 takes ADC 1 and the other way round
  // loopback keeps channel order, sum n goes to out n
  always_ff @(posedge adc_clk) begin
    if (!adc_rstn_i) begin
      adc_dat_o <= '0;
    end else begin
      for (int ch = 0; ch < rp_pkg::CH_N; ch++) begin
        if (digital_loop_i) begin
          adc_dat_o[ch] <= dac_sum_i[ch][rp_pkg::DAC_W-1:TRUNC_LSB];  // sum bits 13..2
        end else begin
          adc_dat_o[ch] <= adc_cnv[rp_pkg::CH_N-1-ch][rp_pkg::ADC_W-1:TRUNC_LSB];
        end
      end
    end
  end

endmodule

/* hdl/rp_dac_mix.sv */
module rp_dac_mix (
  input  logic adc_clk,
  input  logic adc_rstn_i,
  input  logic signed [rp_pkg::CH_N-1:0][rp_pkg::DAC_W-1:0] asg_dat_i,  // generator
  input  logic signed [rp_pkg::CH_N-1:0][rp_pkg::DAC_W-1:0] pid_dat_i,  // controller
  output logic        [rp_pkg::CH_N-1:0][rp_pkg::SUM_W-1:0] dac_sum_o,  // for loopback
  output logic        [rp_pkg::CH_N-1:0][rp_pkg::DAC_W-1:0] dac_dat_o   // to converter
);

  logic [rp_pkg::CH_N-1:0][rp_pkg::DAC_W-1:0] dac_sat;  // saturated, two's complement
  logic [rp_pkg::CH_N-1:0][rp_pkg::DAC_W-1:0] dac_cnv;  // converter code, stage 1

  //////////////////////////////////////////////////////////////////////
  // sum and saturation
  //////////////////////////////////////////////////////////////////////

  // packed element selects lose the sign, so mark them again
  always_comb begin
    for (int ch = 0; ch < rp_pkg::CH_N; ch++) begin
      dac_sum_o[ch] = $signed(asg_dat_i[ch]) + $signed(pid_dat_i[ch]);  // sign extended
    end
  end

  // overflow when guard bit and msb disagree
  always_comb begin
    for (int ch = 0; ch < rp_pkg::CH_N; ch++) begin
      if (dac_sum_o[ch][rp_pkg::SUM_W-1] ^ dac_sum_o[ch][rp_pkg::SUM_W-2]) begin
        if (dac_sum_o[ch][rp_pkg::SUM_W-1]) begin
          dac_sat[ch] = rp_pkg::DAC_NEG_SAT;  // negative full scale
        end else begin
          dac_sat[ch] = rp_pkg::DAC_POS_SAT;  // positive full scale
        end
      end else begin
        dac_sat[ch] = dac_sum_o[ch][rp_pkg::DAC_W-1:0];  // fits, drop guard bit
      end
    end
  end

  //////////////////////////////////////////////////////////////////////
  // code inversion and crossing
  //////////////////////////////////////////////////////////////////////

  // converter wants all bits inverted
  always_ff @(posedge adc_clk) begin
    for (int ch = 0; ch < rp_pkg::CH_N; ch++) begin
      dac_cnv[ch] <= ~dac_sat[ch];
    end
  end

  always_ff @(posedge adc_clk) begin
    if (!adc_rstn_i) begin
      dac_dat_o <= '0;
    end else begin
      for (int ch = 0; ch < rp_pkg::CH_N; ch++) begin
        dac_dat_o[ch] <= dac_cnv[rp_pkg::CH_N-1-ch];  // ch 1 -> dac 0, ch 0 -> dac 1
      end
    end
  end

endmodule

/* hdl/rp_trig_route.sv */
module rp_trig_route (
  input  logic adc_clk,
  input  logic adc_rstn_i,
  input  logic trig_i,                              // external trigger pin
  input  logic [rp_pkg::MODE_W-1:0]  daisy_mode_i,
  input  logic [rp_pkg::DAISY_W-1:0] par_dat_i,     // received daisy word
  input  logic rx_rdy_i,                            // daisy receiver ready
  input  logic scope_trig_i,
  input  logic asg_trig_i,
  input  logic [rp_pkg::EXP_W-1:0]   gpio_n_out_i,
  input  logic [rp_pkg::EXP_W-1:0]   gpio_n_dir_i,  // 1 = output
  output logic trig_ext_o,
  output logic [rp_pkg::DAISY_W-1:0] par_dat_o,     // daisy transmit word
  output logic par_dv_o,
  output logic [rp_pkg::EXP_W-1:0]   exp_n_out_o,
  output logic [rp_pkg::EXP_W-1:0]   exp_n_oe_o
);

  logic daisy_trig;  // any bit set on the incoming word
  logic sync_mode;
  logic trig_sel;    // trigger sent down the chain / out on pin 0

  assign sync_mode = daisy_mode_i[rp_pkg::MODE_SYNC];

  //////////////////////////////////////////////////////////////////////
  // daisy trigger and external gating
  //////////////////////////////////////////////////////////////////////

  always_ff @(posedge adc_clk) begin
    if (!adc_rstn_i) begin
      daisy_trig <= 1'b0;
    end else begin
      daisy_trig <= |par_dat_i;
    end
  end

  // chain trigger blocks the local pin while synced
  assign trig_ext_o = trig_i & ~(sync_mode & daisy_trig);

  assign trig_sel = daisy_mode_i[rp_pkg::MODE_ASG_TRIG] ? asg_trig_i : scope_trig_i;

  //////////////////////////////////////////////////////////////////////
  // daisy transmit
  //////////////////////////////////////////////////////////////////////

  // sync: trigger on every bit, no valid; else idle pattern for link test
  assign par_dat_o = sync_mode ? {rp_pkg::DAISY_W{trig_sel}} : rp_pkg::DAISY_IDLE_PAT;
  assign par_dv_o  = sync_mode ? 1'b0 : rx_rdy_i;

  //////////////////////////////////////////////////////////////////////
  // expansion connector, n side
  //////////////////////////////////////////////////////////////////////

  // only pin 0 has an alternate function
  always_comb begin
    exp_n_out_o = gpio_n_out_i;  // plain GPIO by default
    exp_n_oe_o  = gpio_n_dir_i;
    if (daisy_mode_i[rp_pkg::MODE_ALT_OUT]) begin
      exp_n_out_o[0] = trig_sel;
      exp_n_oe_o[0]  = 1'b1;     // forced output
    end
  end

endmodule

/* hdl/rp_analog_top.sv */
module rp_analog_top (
  input  logic adc_clk,
  input  logic rst_n_i,
  // clocking status
  input  logic pll_locked_i,
  input  logic idly_rdy_i,
  // configuration
  input  logic digital_loop_i,
  input  logic [rp_pkg::MODE_W-1:0] daisy_mode_i,
  // ADC / DAC streams
  input  logic        [rp_pkg::CH_N-1:0][rp_pkg::ADC_W-1:0] adc_raw_i,
  input  logic signed [rp_pkg::CH_N-1:0][rp_pkg::DAC_W-1:0] asg_dat_i,
  input  logic signed [rp_pkg::CH_N-1:0][rp_pkg::DAC_W-1:0] pid_dat_i,
  // triggers and daisy
  input  logic trig_i,
  input  logic [rp_pkg::DAISY_W-1:0] par_dat_i,
  input  logic rx_rdy_i,
  input  logic scope_trig_i,
  input  logic asg_trig_i,
  // expansion GPIO
  input  logic [rp_pkg::EXP_W-1:0] gpio_n_out_i,
  input  logic [rp_pkg::EXP_W-1:0] gpio_n_dir_i,
  output logic [rp_pkg::CH_N-1:0][rp_pkg::ADC_TRUNC_W-1:0] adc_dat_o,
  output logic [rp_pkg::CH_N-1:0][rp_pkg::DAC_W-1:0]       dac_dat_o,
  output logic dac_reset_o,
  output logic trig_ext_o,
  output logic [rp_pkg::DAISY_W-1:0] par_dat_o,
  output logic par_dv_o,
  output logic [rp_pkg::EXP_W-1:0] exp_n_out_o,
  output logic [rp_pkg::EXP_W-1:0] exp_n_oe_o
);

  logic adc_rstn;  // ADC domain reset
  logic [rp_pkg::CH_N-1:0][rp_pkg::SUM_W-1:0] dac_sum;  // loopback source

  //////////////////////////////////////////////////////////////////////
  // reset
  //////////////////////////////////////////////////////////////////////

  rp_reset_seq u_reset_seq (
    .adc_clk      (adc_clk),
    .rst_n_i      (rst_n_i),
    .pll_locked_i (pll_locked_i),
    .idly_rdy_i   (idly_rdy_i),
    .adc_rstn_o   (adc_rstn)
  );

  always_ff @(posedge adc_clk) begin
    dac_reset_o <= ~adc_rstn;  // DAC reset is active high
  end

  //////////////////////////////////////////////////////////////////////
  // analog path
  //////////////////////////////////////////////////////////////////////

  rp_adc_capture u_adc_capture (
    .adc_clk        (adc_clk),
    .adc_rstn_i     (adc_rstn),
    .digital_loop_i (digital_loop_i),
    .adc_raw_i      (adc_raw_i),
    .dac_sum_i      (dac_sum),
    .adc_dat_o      (adc_dat_o)
  );

  rp_dac_mix u_dac_mix (
    .adc_clk    (adc_clk),
    .adc_rstn_i (adc_rstn),
    .asg_dat_i  (asg_dat_i),
    .pid_dat_i  (pid_dat_i),
    .dac_sum_o  (dac_sum),
    .dac_dat_o  (dac_dat_o)
  );

  //////////////////////////////////////////////////////////////////////
  // triggers
  //////////////////////////////////////////////////////////////////////

  rp_trig_route u_trig_route (
    .adc_clk      (adc_clk),
    .adc_rstn_i   (adc_rstn),
    .trig_i       (trig_i),
    .daisy_mode_i (daisy_mode_i),
    .par_dat_i    (par_dat_i),
    .rx_rdy_i     (rx_rdy_i),
    .scope_trig_i (scope_trig_i),
    .asg_trig_i   (asg_trig_i),
    .gpio_n_out_i (gpio_n_out_i),
    .gpio_n_dir_i (gpio_n_dir_i),
    .trig_ext_o   (trig_ext_o),
    .par_dat_o    (par_dat_o),
    .par_dv_o     (par_dv_o),
    .exp_n_out_o  (exp_n_out_o),
    .exp_n_oe_o   (exp_n_oe_o)
  );

endmodule

/* verif/rp_analog_properties.sv */
module rp_analog_properties (
  input logic adc_clk,
  input logic adc_rstn_i,                         // ADC domain reset
  input logic dac_reset_i,
  input logic [rp_pkg::MODE_W-1:0]  daisy_mode_i,
  input logic [rp_pkg::DAISY_W-1:0] par_dat_i,
  input logic par_dv_i,
  input logic trig_ext_i,
  input logic [rp_pkg::EXP_W-1:0]   exp_n_oe_i
);
  timeunit 1ns;
  timeprecision 1ps;

  //////////////////////////////////////////////////////////////////////
  // reset and trigger rules
  //////////////////////////////////////////////////////////////////////

  a_dac_reset: assert property (@(posedge adc_clk) !adc_rstn_i |=> dac_reset_i)
    else $error("dac_reset_o stayed low after the ADC reset was asserted");

  a_sync_no_dv: assert property (@(posedge adc_clk)
    daisy_mode_i[rp_pkg::MODE_SYNC] |-> !par_dv_i)
    else $error("par_dv_o high in daisy sync mode");

  a_alt_oe: assert property (@(posedge adc_clk)
    daisy_mode_i[rp_pkg::MODE_ALT_OUT] |-> exp_n_oe_i[0])
    else $error("expansion pin 0 not driven in alternate mode");

  // daisy_trig is last cycle's word OR, cleared while in reset
  a_trig_block: assert property (@(posedge adc_clk)
    (daisy_mode_i[rp_pkg::MODE_SYNC] && $past(adc_rstn_i) && $past(|par_dat_i))
      |-> !trig_ext_i)
    else $error("external trigger passed while the chain trigger was active");

endmodule

bind rp_analog_top rp_analog_properties u_properties (
  .adc_clk      (adc_clk),
  .adc_rstn_i   (adc_rstn),
  .dac_reset_i  (dac_reset_o),
  .daisy_mode_i (daisy_mode_i),
  .par_dat_i    (par_dat_i),
  .par_dv_i     (par_dv_o),
  .trig_ext_i   (trig_ext_o),
  .exp_n_oe_i   (exp_n_oe_o)
);

/* verif/rp_analog_tb.sv */
module rp_analog_tb;
  timeunit 1ns;
  timeprecision 1ps;

  logic adc_clk;
  logic rst_n_i;
  logic pll_locked_i;
  logic idly_rdy_i;
  logic digital_loop_i;
  logic [rp_pkg::MODE_W-1:0] daisy_mode_i;
  logic        [rp_pkg::CH_N-1:0][rp_pkg::ADC_W-1:0] adc_raw_i;
  logic signed [rp_pkg::CH_N-1:0][rp_pkg::DAC_W-1:0] asg_dat_i;
  logic signed [rp_pkg::CH_N-1:0][rp_pkg::DAC_W-1:0] pid_dat_i;
  logic trig_i;
  logic [rp_pkg::DAISY_W-1:0] par_dat_i;
  logic rx_rdy_i;
  logic scope_trig_i;
  logic asg_trig_i;
  logic [rp_pkg::EXP_W-1:0] gpio_n_out_i;
  logic [rp_pkg::EXP_W-1:0] gpio_n_dir_i;
  logic [rp_pkg::CH_N-1:0][rp_pkg::ADC_TRUNC_W-1:0] adc_dat_o;
  logic [rp_pkg::CH_N-1:0][rp_pkg::DAC_W-1:0]       dac_dat_o;
  logic dac_reset_o;
  logic trig_ext_o;
  logic [rp_pkg::DAISY_W-1:0] par_dat_o;
  logic par_dv_o;
  logic [rp_pkg::EXP_W-1:0] exp_n_out_o;
  logic [rp_pkg::EXP_W-1:0] exp_n_oe_o;

  logic [15:0] vec [21];  // one parsed line: 13 stimulus fields, 8 expected
  int errors;
  int timeouts;
  int checks;
  int vectors;

  rp_analog_top dut0 (.*);

  initial begin
    adc_clk = 1'b0;
    forever #20 adc_clk = ~adc_clk;  // 40 ns
  end

  //////////////////////////////////////////////////////////////////////
  // helpers
  //////////////////////////////////////////////////////////////////////

  task automatic compare_value(input string name, input logic [31:0] expected,
                               input logic [31:0] actual);
    checks++;
    if (actual !== expected) begin
      errors++;
      $display("Mismatch at %0t: %s expected %h, got %h", $time, name, expected, actual);
    end
  endtask

  // poll dac_reset_o once per cycle at the falling edge
  task automatic wait_dac_reset(input logic level, input int max_cycles,
                                output int cycles, output bit reached);
    cycles  = 0;
    reached = 1'b0;
    while (!reached && cycles < max_cycles) begin
      @(posedge adc_clk);
      @(negedge adc_clk);
      cycles++;
      reached = (dac_reset_o === level);
    end
    if (!reached) begin
      timeouts++;
      $display("Timeout at %0t: dac_reset_o never went to %b within %0d cycles",
               $time, level, max_cycles);
    end
  endtask

  task automatic apply_and_check();
    @(posedge adc_clk);
    digital_loop_i <= vec[0][0];
    daisy_mode_i   <= vec[1][rp_pkg::MODE_W-1:0];
    trig_i         <= vec[2][0];
    par_dat_i      <= vec[3];
    rx_rdy_i       <= vec[4][0];
    scope_trig_i   <= vec[5][0];
    asg_trig_i     <= vec[6][0];
    adc_raw_i[0]   <= vec[7][13:0];
    adc_raw_i[1]   <= vec[8][13:0];
    asg_dat_i[0]   <= vec[9][13:0];
    asg_dat_i[1]   <= vec[10][13:0];
    pid_dat_i[0]   <= vec[11][13:0];
    pid_dat_i[1]   <= vec[12][13:0];
    repeat (4) @(posedge adc_clk);  // longer than any 2 cycle path
    @(negedge adc_clk);
    compare_value("adc_dat_o[0]", vec[13], adc_dat_o[0]);
    compare_value("adc_dat_o[1]", vec[14], adc_dat_o[1]);
    compare_value("dac_dat_o[0]", vec[15], dac_dat_o[0]);
    compare_value("dac_dat_o[1]", vec[16], dac_dat_o[1]);
    compare_value("trig_ext_o", vec[17], trig_ext_o);
    compare_value("par_dat_o", vec[18], par_dat_o);
    compare_value("par_dv_o", vec[19], par_dv_o);
    compare_value("exp_n_out_o[0]", vec[20], exp_n_out_o[0]);
    compare_value("exp_n_oe_o[0]", vec[1][rp_pkg::MODE_ALT_OUT] | gpio_n_dir_i[0],
                  exp_n_oe_o[0]);  // forced output in alt mode
    compare_value("exp_n_out_o[7:1]", gpio_n_out_i[7:1], exp_n_out_o[7:1]);  // plain GPIO
    compare_value("exp_n_oe_o[7:1]", gpio_n_dir_i[7:1], exp_n_oe_o[7:1]);
  endtask

  //////////////////////////////////////////////////////////////////////
  // main sequence
  //////////////////////////////////////////////////////////////////////

  initial begin
    int fd;
    int n;
    int cycles;
    bit reached;
    string line;
    $timeformat(-9, 0, " ns", 0);
    errors         = 0;
    timeouts       = 0;
    checks         = 0;
    vectors        = 0;
    rst_n_i        = 1'b0;
    pll_locked_i   = 1'b0;
    idly_rdy_i     = 1'b0;
    digital_loop_i = 1'b0;
    daisy_mode_i   = '0;
    adc_raw_i      = '0;
    asg_dat_i      = '0;
    pid_dat_i      = '0;
    trig_i         = 1'b0;
    par_dat_i      = '0;
    rx_rdy_i       = 1'b0;
    scope_trig_i   = 1'b0;
    asg_trig_i     = 1'b0;
    gpio_n_out_i   = 8'ha5;  // bit 0 set, differs from a low trigger
    gpio_n_dir_i   = 8'h3c;

    // board reset for 5 cycles, outputs must sit at reset values
    repeat (4) @(posedge adc_clk);
    @(negedge adc_clk);
    compare_value("dac_reset_o", 1, dac_reset_o);
    compare_value("adc_dat_o", 0, adc_dat_o);
    compare_value("dac_dat_o", 0, dac_dat_o);
    @(posedge adc_clk);
    rst_n_i    <= 1'b1;
    idly_rdy_i <= 1'b1;  // PLL still unlocked
    repeat (8) @(posedge adc_clk);
    @(negedge adc_clk);
    compare_value("dac_reset_o", 1, dac_reset_o);
    @(posedge adc_clk);
    pll_locked_i <= 1'b1;
    wait_dac_reset(1'b0, 40, cycles, reached);
    if (reached && cycles < rp_pkg::RST_LEN) begin
      errors++;
      $display("Reset was released only %0d cycles after lock", cycles);
    end

    if (reached) begin
      fd = $fopen("verif/rp_analog_cases.txt", "r");
      if (fd == 0) begin
        errors++;
        $display("Could not open the vector file verif/rp_analog_cases.txt");
      end else begin
        while ($fgets(line, fd) != 0) begin
          if (line.len() > 1 && line.getc(0) != "#") begin  // skip comments, blanks
            n = $sscanf(line,
              "%h %h %h %h %h %h %h %h %h %h %h %h %h %h %h %h %h %h %h %h %h",
              vec[0], vec[1], vec[2], vec[3], vec[4], vec[5], vec[6],
              vec[7], vec[8], vec[9], vec[10], vec[11], vec[12], vec[13],
              vec[14], vec[15], vec[16], vec[17], vec[18], vec[19], vec[20]);
            if (n == 21) begin
              vectors++;
              apply_and_check();
            end else begin
              errors++;
              $display("Vector line has %0d fields instead of 21: %s", n, line);
            end
          end
        end
        $fclose(fd);
      end
      if (vectors == 0) begin
        errors++;
        $display("No vectors were read from the vector file");
      end

      // losing lock pulls everything back into reset
      @(posedge adc_clk);
      pll_locked_i <= 1'b0;
      wait_dac_reset(1'b1, 10, cycles, reached);
      if (reached) begin
        compare_value("adc_dat_o", 0, adc_dat_o);
        compare_value("dac_dat_o", 0, dac_dat_o);
      end
    end

    $display("vectors %0d, checks %0d, errors %0d, timeouts %0d",
             vectors, checks, errors, timeouts);
    if (errors == 0 && timeouts == 0) begin
      $display("*** PASSED ***");
    end else begin
      $display("*** FAILED ***");
    end
    $finish;
  end

endmodule

/* verif/rp_analog_cases.txt */
# loop mode trig par_dat rx scope asg raw0 raw1 asg0 asg1 pid0 pid1, all hex, then expected:
# adc_dat0 adc_dat1 dac_dat0 dac_dat1 trig_ext par_dat_o par_dv exp_n_out0 (gpio_n_out = a5)
0 0 1 0000 1 0 0 0000 3fff 0000 0000 0000 0000 800 7ff 3fff 3fff 1 1234 1 1
0 0 0 0000 0 1 0 2000 1abc 0100 0050 0023 3ff0 150 fff 3fbf 3edc 0 1234 0 1
0 0 1 00ff 1 0 1 1555 2aaa 1fff 0abc 0001 0001 d55 2aa 3542 2000 1 1234 1 1
0 1 1 0001 1 1 0 3fff 0000 3000 2000 3800 3fff 7ff 800 1fff 17ff 0 ffff 0 1
0 1 1 0000 1 0 0 0800 3000 0000 3fff 0000 3fff bff 5ff 0001 3fff 1 0000 0 1
0 2 0 0000 0 0 1 0000 3fff 0000 0000 0000 0000 800 7ff 3fff 3fff 0 1234 0 0
0 6 1 ffff 1 1 0 1abc 2000 0050 0100 3ff0 0023 fff 150 3edc 3fbf 1 1234 1 0
0 7 1 8000 1 0 1 2aaa 1555 0000 0000 0000 0000 2aa d55 3fff 3fff 0 ffff 0 1
0 5 0 0010 1 0 1 0000 0000 0000 0000 0000 0000 7ff 7ff 3fff 3fff 0 ffff 0 1
1 0 0 0000 1 0 0 0000 3fff 0100 0050 0023 3ff0 048 010 3fbf 3edc 0 1234 1 1
1 0 1 0000 0 0 0 1234 0abc 1fff 2000 0001 3fff 800 7ff 1fff 2000 1 1234 0 1
1 3 1 0000 1 1 0 0000 0000 3000 3fff 3800 3fff a00 fff 0001 17ff 1 ffff 0 1
0 3 1 0f00 1 0 1 0123 3ede 1000 2000 1000 2000 848 7b7 1fff 2000 0 0000 0 0

/* rp_analog_top.f */
hdl/rp_pkg.sv
hdl/rp_reset_seq.sv
hdl/rp_adc_capture.sv
hdl/rp_dac_mix.sv
hdl/rp_trig_route.sv
hdl/rp_analog_top.sv
verif/rp_analog_properties.sv
verif/rp_analog_tb.sv

/* run_sim.sh */
#!/usr/bin/env bash
# build and run the analog path testbench with Verilator
cd "$(dirname "$0")" || exit 1
rm -rf obj_dir build.log sim.log

verilator --binary --assert --timescale 1ns/1ps -Wno-fatal \
  --top-module rp_analog_tb -o rp_analog_sim -f rp_analog_top.f \
  > build.log 2>&1 || { echo "build failed, see build.log"; exit 1; }

./obj_dir/rp_analog_sim > sim.log 2>&1
grep -q '^\*\*\* PASSED \*\*\*$' sim.log && echo "simulation passed" \
  || { echo "simulation failed, see sim.log"; exit 1; }
